//--- Makefile
TOP := execUnit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o simv
	./obj_dir/simv | tee sim.log
	@if grep -q "Test failures found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed!" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- build.f
hw/cr16Pkg.sv
hw/execPkg.sv
hw/aluController.sv
hw/aluCore.sv
hw/condEval.sv
hw/execCombine.sv
hw/execUnit.sv
sim/execUnit_checker.sv
sim/execUnit_tb.sv

//--- hw/aluController.sv
`timescale 1ns/1ps
`default_nettype none

// opcode/func -> alu control + psr write mask
module aluController (
    input  cr16Pkg::opcode_t  op,
    input  cr16Pkg::func_t    func,
    output execPkg::aluCont_t aluCont,
    output execPkg::psr_t     psrWrEn
);

    ////////////////////
    // masks, bit order C L F Z N
    localparam execPkg::psr_t maskNone  = 5'b00000;
    localparam execPkg::psr_t maskLogic = 5'b00010; // Z only
    localparam execPkg::psr_t maskArith = 5'b10111; // C F Z N
    localparam execPkg::psr_t maskCmp   = 5'b01011; // L Z N

    always_comb begin
        // unlisted combos fall out as add, no flags
        aluCont = execPkg::aluAdd;
        psrWrEn = maskNone;

        case (op)
            cr16Pkg::opReg: begin
                case (func)
                    cr16Pkg::fnAnd,
                    cr16Pkg::fnTest: begin // test = and, result dropped by sw
                        aluCont = execPkg::aluAnd;
                        psrWrEn = maskLogic;
                    end
                    cr16Pkg::fnOr: begin
                        aluCont = execPkg::aluOr;
                        psrWrEn = maskLogic;
                    end
                    cr16Pkg::fnXor: begin
                        aluCont = execPkg::aluXor;
                        psrWrEn = maskLogic;
                    end
                    cr16Pkg::fnNot: begin
                        aluCont = execPkg::aluNot;
                        psrWrEn = maskLogic;
                    end
                    cr16Pkg::fnAdd,
                    cr16Pkg::fnAddc: begin // no carry-in here
                        aluCont = execPkg::aluAdd;
                        psrWrEn = maskArith;
                    end
                    cr16Pkg::fnAddu: aluCont = execPkg::aluAdd; // flags untouched
                    cr16Pkg::fnSub,
                    cr16Pkg::fnSubc: begin
                        aluCont = execPkg::aluSub;
                        psrWrEn = maskArith;
                    end
                    cr16Pkg::fnCmp: begin
                        aluCont = execPkg::aluSub;
                        psrWrEn = maskCmp;
                    end
                    cr16Pkg::fnMov: aluCont = execPkg::aluMov;
                    cr16Pkg::fnMul: aluCont = execPkg::aluMul;
                    default: ;
                endcase
            end

            cr16Pkg::opSpecial: begin
                case (func)
                    cr16Pkg::fnJal:   aluCont = execPkg::aluMov;   // link via src
                    cr16Pkg::fnJcond: aluCont = execPkg::aluJcond;
                    cr16Pkg::fnScond: aluCont = execPkg::aluScond;
                    default: ;
                endcase
            end

            cr16Pkg::opShift: begin
                case (func)
                    cr16Pkg::fnLshiL,
                    cr16Pkg::fnAshuiL: aluCont = execPkg::aluShl;
                    cr16Pkg::fnLshiR:  aluCont = execPkg::aluLshiR;
                    cr16Pkg::fnAshuiR: aluCont = execPkg::aluAshiR;
                    cr16Pkg::fnLsh:    aluCont = execPkg::aluLsh;
                    cr16Pkg::fnAshu:   aluCont = execPkg::aluAshu;
                    default: ;
                endcase
            end

            cr16Pkg::opBcond: aluCont = execPkg::aluBcond;

            ////////////////////
            // immediate forms
            cr16Pkg::opAndi: begin
                aluCont = execPkg::aluAnd;
                psrWrEn = maskLogic;
            end
            cr16Pkg::opOri: begin
                aluCont = execPkg::aluOr;
                psrWrEn = maskLogic;
            end
            cr16Pkg::opXori: begin
                aluCont = execPkg::aluXor;
                psrWrEn = maskLogic;
            end
            cr16Pkg::opAddi,
            cr16Pkg::opAddci: begin
                aluCont = execPkg::aluAdd;
                psrWrEn = maskArith;
            end
            cr16Pkg::opAddui: aluCont = execPkg::aluAdd;
            cr16Pkg::opSubi,
            cr16Pkg::opSubci: begin
                aluCont = execPkg::aluSub;
                psrWrEn = maskArith;
            end
            cr16Pkg::opCmpi: begin
                aluCont = execPkg::aluSub;
                psrWrEn = maskCmp;
            end
            cr16Pkg::opMovi: aluCont = execPkg::aluMov;
            cr16Pkg::opMuli: aluCont = execPkg::aluMul;
            cr16Pkg::opLui:  aluCont = execPkg::aluLui;

            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/aluCore.sv
`timescale 1ns/1ps
`default_nettype none

// result + raw flags, masking happens downstream
module aluCore (
    input  execPkg::aluCont_t aluCont,
    input  cr16Pkg::word_t    dst,
    input  cr16Pkg::word_t    src,
    output cr16Pkg::word_t    coreResult,
    output execPkg::psr_t     coreFlags
);

    logic [16:0]    sum;     // carry in bit 16
    logic [16:0]    diff;    // borrow in bit 16
    logic           addOvf;
    logic           subOvf;
    logic [4:0]     negAmt;  // -src[4:0], 16 when src[4:0] is -16
    cr16Pkg::word_t shl;
    cr16Pkg::word_t shrLog;
    cr16Pkg::word_t shrAri;
    cr16Pkg::word_t mulLo;

    ////////////////////
    // shared arithmetic
    assign sum    = {1'b0, dst} + {1'b0, src};
    assign diff   = {1'b0, dst} - {1'b0, src};
    assign addOvf = (dst[15] == src[15]) && (sum[15] != dst[15]);
    assign subOvf = (dst[15] != src[15]) && (diff[15] != dst[15]);
    assign mulLo  = dst * src;  // truncated to 16

    // shifts, right amount can reach 16 which clears / sign fills
    assign negAmt = 5'd0 - src[4:0];
    assign shl    = dst << src[3:0];
    assign shrLog = dst >> negAmt;
    assign shrAri = cr16Pkg::word_t'($signed(dst) >>> negAmt);

    always_comb begin
        case (aluCont)
            execPkg::aluAdd,
            execPkg::aluBcond: coreResult = sum[15:0];   // bcond target = dst + disp
            execPkg::aluSub:   coreResult = diff[15:0];
            execPkg::aluMul:   coreResult = mulLo;
            execPkg::aluAnd:   coreResult = dst & src;
            execPkg::aluOr:    coreResult = dst | src;
            execPkg::aluXor:   coreResult = dst ^ src;
            execPkg::aluNot:   coreResult = ~dst;
            execPkg::aluMov,
            execPkg::aluJcond: coreResult = src;
            execPkg::aluLui:   coreResult = {src[7:0], dst[7:0]};
            execPkg::aluLsh:   coreResult = src[4] ? shrLog : shl; // src<0 -> right
            execPkg::aluAshu:  coreResult = src[4] ? shrAri : shl;
            execPkg::aluShl:   coreResult = shl;
            execPkg::aluLshiR: coreResult = shrLog;
            execPkg::aluAshiR: coreResult = shrAri;
            execPkg::aluScond: coreResult = '0;          // combiner fills in 1/0
            default:           coreResult = sum[15:0];
        endcase
    end

    ////////////////////
    // flags
    always_comb begin
        coreFlags   = '0;
        coreFlags.z = (coreResult == '0);
        coreFlags.n = coreResult[15];

        if (aluCont == execPkg::aluAdd) begin
            coreFlags.c = sum[16];
            coreFlags.f = addOvf;
        end else if (aluCont == execPkg::aluSub) begin
            coreFlags.c = diff[16];          // borrow
            coreFlags.f = subOvf;
            coreFlags.l = diff[16];          // unsigned dst < src
            // cmp reads N as signed dst < src, sub shares the code
            coreFlags.n = diff[15] ^ subOvf;
        end
    end

endmodule

`default_nettype wire

//--- hw/condEval.sv
`timescale 1ns/1ps
`default_nettype none

// condition test against current psr
module condEval (
    input  execPkg::aluCont_t aluCont,
    input  cr16Pkg::cond_t    cond,
    input  cr16Pkg::word_t    src,
    input  execPkg::psr_t     psr,
    output logic              condTrue
);

    cr16Pkg::cond_t code;

    // scond carries its code in the source operand
    assign code = (aluCont == execPkg::aluScond) ? src[3:0] : cond;

    always_comb begin
        case (code)
            cr16Pkg::condEq:    condTrue = psr.z;
            cr16Pkg::condNe:    condTrue = !psr.z;
            cr16Pkg::condCs:    condTrue = psr.c;
            cr16Pkg::condCc:    condTrue = !psr.c;
            cr16Pkg::condHi:    condTrue = psr.l;
            cr16Pkg::condLs:    condTrue = !psr.l;
            cr16Pkg::condGt:    condTrue = psr.n;
            cr16Pkg::condLe:    condTrue = !psr.n;
            cr16Pkg::condFs:    condTrue = psr.f;
            cr16Pkg::condFc:    condTrue = !psr.f;
            cr16Pkg::condLt:    condTrue = !(psr.n || psr.z); // neither N nor Z
            cr16Pkg::condGe:    condTrue = psr.n || psr.z;
            cr16Pkg::condLo:    condTrue = !(psr.l || psr.z);
            cr16Pkg::condHs:    condTrue = psr.l || psr.z;
            cr16Pkg::condUc:    condTrue = 1'b1;
            cr16Pkg::condNever: condTrue = 1'b0;
            default:            condTrue = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/cr16Pkg.sv
`default_nettype none

// instruction-set level types and codes
package cr16Pkg;

    ////////////////////
    // field types
    typedef logic [15:0] word_t;   // data word
    typedef logic [3:0]  opcode_t; // major opcode
    typedef logic [3:0]  func_t;   // minor op for reg/special/shift classes
    typedef logic [3:0]  cond_t;   // branch/jump/set condition

    ////////////////////
    // opcodes, immediate forms share the reg func numbering
    localparam opcode_t opReg     = 4'b0000; // register class, func picks op
    localparam opcode_t opAndi    = 4'b0001;
    localparam opcode_t opOri     = 4'b0010;
    localparam opcode_t opXori    = 4'b0011;
    localparam opcode_t opSpecial = 4'b0100; // jumps, scond
    localparam opcode_t opAddi    = 4'b0101;
    localparam opcode_t opAddci   = 4'b0110; // carry-in ignored
    localparam opcode_t opAddui   = 4'b0111;
    localparam opcode_t opShift   = 4'b1000; // shift class
    localparam opcode_t opSubi    = 4'b1001;
    localparam opcode_t opSubci   = 4'b1010; // borrow-in ignored
    localparam opcode_t opCmpi    = 4'b1011;
    localparam opcode_t opBcond   = 4'b1100;
    localparam opcode_t opMovi    = 4'b1101;
    localparam opcode_t opMuli    = 4'b1110;
    localparam opcode_t opLui     = 4'b1111;

    ////////////////////
    // register class func codes
    localparam func_t fnAnd  = 4'b0001;
    localparam func_t fnOr   = 4'b0010;
    localparam func_t fnXor  = 4'b0011;
    localparam func_t fnNot  = 4'b0100;
    localparam func_t fnAdd  = 4'b0101;
    localparam func_t fnAddc = 4'b0110;
    localparam func_t fnAddu = 4'b0111;
    localparam func_t fnSub  = 4'b1001;
    localparam func_t fnSubc = 4'b1010;
    localparam func_t fnCmp  = 4'b1011;
    localparam func_t fnMov  = 4'b1101;
    localparam func_t fnMul  = 4'b1110;
    localparam func_t fnTest = 4'b1111; // and, only flags kept

    // special class
    localparam func_t fnJal   = 4'b1000;
    localparam func_t fnJcond = 4'b1100;
    localparam func_t fnScond = 4'b1101;

    // shift class
    localparam func_t fnLshiL  = 4'b0000;
    localparam func_t fnLshiR  = 4'b0001;
    localparam func_t fnAshuiL = 4'b0010;
    localparam func_t fnAshuiR = 4'b0011;
    localparam func_t fnLsh    = 4'b0100;
    localparam func_t fnAshu   = 4'b0110;

    ////////////////////
    // condition codes
    localparam cond_t condEq    = 4'd0;
    localparam cond_t condNe    = 4'd1;
    localparam cond_t condCs    = 4'd2;
    localparam cond_t condCc    = 4'd3;
    localparam cond_t condHi    = 4'd4;
    localparam cond_t condLs    = 4'd5;
    localparam cond_t condGt    = 4'd6;
    localparam cond_t condLe    = 4'd7;
    localparam cond_t condFs    = 4'd8;
    localparam cond_t condFc    = 4'd9;
    localparam cond_t condLt    = 4'd10;
    localparam cond_t condGe    = 4'd11;
    localparam cond_t condLo    = 4'd12;
    localparam cond_t condHs    = 4'd13;
    localparam cond_t condUc    = 4'd14; // unconditional
    localparam cond_t condNever = 4'd15;

endpackage

`default_nettype wire

//--- hw/execCombine.sv
`timescale 1ns/1ps
`default_nettype none

// final select, psr update, one-entry output register
module execCombine (
    input  logic              clk,
    input  logic              arstN,
    input  logic              reqValid,
    input  execPkg::execReq_t req,
    input  execPkg::aluCont_t aluCont,
    input  execPkg::psr_t     psrWrEn,
    input  cr16Pkg::word_t    coreResult,
    input  execPkg::psr_t     coreFlags,
    input  logic              condTrue,
    input  logic              rspReady,
    output logic              reqReady,
    output logic              rspValid,
    output execPkg::execRsp_t rsp,
    output execPkg::psr_t     psr
);

    logic           accept;
    cr16Pkg::word_t result;
    execPkg::psr_t  psrNext;

    ////////////////////
    // handshake
    assign reqReady = !rspValid || rspReady;  // empty or draining
    assign accept   = reqValid && reqReady;

    ////////////////////
    // result select
    always_comb begin
        case (aluCont)
            execPkg::aluBcond,
            execPkg::aluJcond: result = condTrue ? coreResult : req.dst; // not taken keeps dst
            execPkg::aluScond: result = {15'd0, condTrue};
            default:           result = coreResult;
        endcase
    end

    // masked merge, untouched bits keep old psr
    assign psrNext = (psr & ~psrWrEn) | (coreFlags & psrWrEn);

    ////////////////////
    // control state
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspValid <= 1'b0;
            psr      <= '0;
        end else begin
            if (accept) begin
                rspValid <= 1'b1;
                psr      <= psrNext;  // next req sees this
            end else if (rspReady) begin
                rspValid <= 1'b0;     // drained, nothing new
            end
        end
    end

    // payload, loads only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp.result   <= result;
            rsp.psr      <= psrNext;
            rsp.condTrue <= condTrue;
            rsp.tag      <= req.tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/execPkg.sv
`default_nettype none

// execute stage types: alu control, psr, request/response
package execPkg;

    ////////////////////
    // alu control
    typedef logic [4:0] aluCont_t;
    typedef logic [7:0] tag_t;    // opaque id, echoed back

    localparam aluCont_t aluAdd   = 5'd0;  // dst + src
    localparam aluCont_t aluSub   = 5'd1;  // dst - src
    localparam aluCont_t aluMul   = 5'd2;  // low half of product
    localparam aluCont_t aluAnd   = 5'd3;
    localparam aluCont_t aluOr    = 5'd4;
    localparam aluCont_t aluXor   = 5'd5;
    // code 6 unassigned
    localparam aluCont_t aluScond = 5'd7;  // 1/0 from cond in src[3:0]
    localparam aluCont_t aluMov   = 5'd8;  // src
    localparam aluCont_t aluLui   = 5'd9;  // src[7:0] over dst[7:0]
    localparam aluCont_t aluNot   = 5'd10; // ~dst
    localparam aluCont_t aluLsh   = 5'd11; // signed amount, logical
    localparam aluCont_t aluShl   = 5'd12; // LSHI/ASHUI left
    localparam aluCont_t aluLshiR = 5'd13; // logical right by -src[4:0]
    localparam aluCont_t aluAshu  = 5'd14; // signed amount, arithmetic
    localparam aluCont_t aluAshiR = 5'd15; // arith right by -src[4:0]
    localparam aluCont_t aluBcond = 5'd16; // cond ? dst + src : dst
    localparam aluCont_t aluJcond = 5'd17; // cond ? src : dst

    ////////////////////
    // psr, also used as write mask
    typedef struct packed {
        logic c; // carry / borrow
        logic l; // unsigned less
        logic f; // signed overflow
        logic z; // zero
        logic n; // negative / signed less on cmp
    } psr_t;

    typedef struct packed {
        cr16Pkg::opcode_t op;
        cr16Pkg::func_t   func;
        cr16Pkg::cond_t   cond;
        cr16Pkg::word_t   dst;
        cr16Pkg::word_t   src;
        tag_t             tag;
    } execReq_t;

    typedef struct packed {
        cr16Pkg::word_t result;
        psr_t           psr;      // after this op's update
        logic           condTrue;
        tag_t           tag;
    } execRsp_t;

endpackage

`default_nettype wire

//--- hw/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

// execute stage top
module execUnit (
    input  logic              clk,
    input  logic              arstN,
    input  logic              reqValid,
    input  execPkg::execReq_t req,
    output logic              reqReady,
    output logic              rspValid,
    output execPkg::execRsp_t rsp,
    input  logic              rspReady
);

    execPkg::aluCont_t aluCont;
    execPkg::psr_t     psrWrEn;
    execPkg::psr_t     coreFlags;
    execPkg::psr_t     psr;        // live psr from combiner
    cr16Pkg::word_t    coreResult;
    logic              condTrue;

    ////////////////////
    // decode
    aluController aluController_i (
        .op      (req.op),
        .func    (req.func),
        .aluCont (aluCont),
        .psrWrEn (psrWrEn)
    );

    // datapath and condition test side by side
    aluCore aluCore_i (
        .aluCont    (aluCont),
        .dst        (req.dst),
        .src        (req.src),
        .coreResult (coreResult),
        .coreFlags  (coreFlags)
    );

    condEval condEval_i (
        .aluCont  (aluCont),
        .cond     (req.cond),
        .src      (req.src),
        .psr      (psr),
        .condTrue (condTrue)
    );

    ////////////////////
    // merge + register
    execCombine execCombine_i (
        .clk        (clk),
        .arstN      (arstN),
        .reqValid   (reqValid),
        .req        (req),
        .aluCont    (aluCont),
        .psrWrEn    (psrWrEn),
        .coreResult (coreResult),
        .coreFlags  (coreFlags),
        .condTrue   (condTrue),
        .rspReady   (rspReady),
        .reqReady   (reqReady),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .psr        (psr)
    );

endmodule

`default_nettype wire

//--- sim/execUnit_checker.sv
`timescale 1ns/1ps
`default_nettype none

// handshake rules on the stage outputs
module execUnit_checker (
    input wire logic              clk,
    input wire logic              arstN,
    input wire logic              reqReady,
    input wire logic              rspValid,
    input wire logic              rspReady,
    input wire execPkg::execRsp_t rsp
);

    int failCount = 0;

    ////////////////////
    // stalled response holds
    assert property (@(posedge clk) disable iff (!arstN)
        (rspValid && !rspReady) |=> (rspValid && $stable(rsp)))
    else begin
        failCount++;
        $error("rsp changed or dropped while stalled");
    end

    assert property (@(posedge clk) !arstN |-> !rspValid)  // empty in reset
    else begin
        failCount++;
        $error("rspValid high during reset");
    end

    // full and blocked, no new request
    assert property (@(posedge clk) disable iff (!arstN)
        (rspValid && !rspReady) |-> !reqReady)
    else begin
        failCount++;
        $error("reqReady high under back-pressure");
    end

endmodule

bind execUnit execUnit_checker execUnitChecker_i (
    .clk      (clk),
    .arstN    (arstN),
    .reqReady (reqReady),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rsp      (rsp)
);

`default_nettype wire

//--- sim/execUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit_tb;

    // operation kinds of the reference model
    typedef enum logic [4:0] {
        kAdd, kSub, kMul, kAnd, kOr, kXor, kNot, kMov, kLui,
        kLsh, kAshu, kShl, kLshR, kAshR, kBcond, kJcond, kScond
    } kind_t;

    localparam int numReqs = 500;

    logic              clk = 1'b0;
    logic              arstN;
    logic              reqValid;
    logic              reqReady;
    logic              rspValid;
    logic              rspReady;
    execPkg::execReq_t req;
    execPkg::execRsp_t rsp;

    integer            seed = 32'h99a0_ae70;
    execPkg::execRsp_t expQ[$];   // in flight, oldest first
    execPkg::psr_t     modelPsr;
    logic              timedOut;
    int                mismatches = 0;
    int                otherErrors = 0;
    int                accepted = 0;
    int                received = 0;

    execUnit execUnit_i (
        .clk      (clk),
        .arstN    (arstN),
        .reqValid (reqValid),
        .req      (req),
        .reqReady (reqReady),
        .rspValid (rspValid),
        .rsp      (rsp),
        .rspReady (rspReady)
    );

    always #50 clk = ~clk;  // 100 ns

    ////////////////////
    // reference model
    function automatic kind_t opKind(input cr16Pkg::opcode_t op, input cr16Pkg::func_t fn);
        case (op)
            cr16Pkg::opReg: begin
                case (fn)
                    cr16Pkg::fnAnd, cr16Pkg::fnTest: return kAnd;
                    cr16Pkg::fnOr:  return kOr;
                    cr16Pkg::fnXor: return kXor;
                    cr16Pkg::fnNot: return kNot;
                    cr16Pkg::fnSub, cr16Pkg::fnSubc, cr16Pkg::fnCmp: return kSub;
                    cr16Pkg::fnMov: return kMov;
                    cr16Pkg::fnMul: return kMul;
                    default: return kAdd;  // add forms and holes
                endcase
            end
            cr16Pkg::opSpecial: begin
                case (fn)
                    cr16Pkg::fnJal:   return kMov;
                    cr16Pkg::fnJcond: return kJcond;
                    cr16Pkg::fnScond: return kScond;
                    default: return kAdd;
                endcase
            end
            cr16Pkg::opShift: begin
                case (fn)
                    cr16Pkg::fnLshiL, cr16Pkg::fnAshuiL: return kShl;
                    cr16Pkg::fnLshiR:  return kLshR;
                    cr16Pkg::fnAshuiR: return kAshR;
                    cr16Pkg::fnLsh:    return kLsh;
                    cr16Pkg::fnAshu:   return kAshu;
                    default: return kAdd;
                endcase
            end
            cr16Pkg::opBcond: return kBcond;
            cr16Pkg::opAndi:  return kAnd;
            cr16Pkg::opOri:   return kOr;
            cr16Pkg::opXori:  return kXor;
            cr16Pkg::opSubi, cr16Pkg::opSubci, cr16Pkg::opCmpi: return kSub;
            cr16Pkg::opMovi:  return kMov;
            cr16Pkg::opMuli:  return kMul;
            cr16Pkg::opLui:   return kLui;
            default: return kAdd;  // addi, addci, addui
        endcase
    endfunction

    // flags written, C L F Z N
    function automatic execPkg::psr_t flagMask(input cr16Pkg::opcode_t op,
                                               input cr16Pkg::func_t fn);
        logic isReg;
        isReg = (op == cr16Pkg::opReg);
        if ((isReg && fn inside {cr16Pkg::fnAnd, cr16Pkg::fnOr, cr16Pkg::fnXor,
                                 cr16Pkg::fnNot, cr16Pkg::fnTest})
            || op inside {cr16Pkg::opAndi, cr16Pkg::opOri, cr16Pkg::opXori})
            return 5'b00010;
        if ((isReg && fn inside {cr16Pkg::fnAdd, cr16Pkg::fnAddc, cr16Pkg::fnSub,
                                 cr16Pkg::fnSubc})
            || op inside {cr16Pkg::opAddi, cr16Pkg::opAddci, cr16Pkg::opSubi,
                          cr16Pkg::opSubci})
            return 5'b10111;
        if ((isReg && fn == cr16Pkg::fnCmp) || op == cr16Pkg::opCmpi)
            return 5'b01011;
        return 5'b00000;  // unsigned forms, mov, mul, shifts, jumps
    endfunction

    function automatic cr16Pkg::word_t shiftRight(input cr16Pkg::word_t v, input int amt,
                                                  input logic arith);
        cr16Pkg::word_t r;
        r = v;
        for (int i = 0; i < amt; i++)
            r = {arith & r[15], r[15:1]};  // one bit per step
        return r;
    endfunction

    function automatic logic condHolds(input cr16Pkg::cond_t c, input execPkg::psr_t p);
        case (c)
            4'd0:  return p.z;
            4'd1:  return !p.z;
            4'd2:  return p.c;
            4'd3:  return !p.c;
            4'd4:  return p.l;
            4'd5:  return !p.l;
            4'd6:  return p.n;
            4'd7:  return !p.n;
            4'd8:  return p.f;
            4'd9:  return !p.f;
            4'd10: return !p.n && !p.z;
            4'd11: return p.n || p.z;
            4'd12: return !p.l && !p.z;
            4'd13: return p.l || p.z;
            4'd14: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic execPkg::execRsp_t predict(input execPkg::execReq_t r,
                                                  input execPkg::psr_t p);
        execPkg::execRsp_t e;
        execPkg::psr_t     raw;
        execPkg::psr_t     mask;
        kind_t             k;
        cr16Pkg::word_t    core;
        logic              ct;
        int                rAmt;
        int                sSum;
        int                sDiff;
        k     = opKind(r.op, r.func);
        mask  = flagMask(r.op, r.func);
        rAmt  = (32 - int'(r.src[4:0])) % 32;  // negated 5-bit amount
        sSum  = int'($signed(r.dst)) + int'($signed(r.src));
        sDiff = int'($signed(r.dst)) - int'($signed(r.src));
        ct    = condHolds((k == kScond) ? r.src[3:0] : r.cond, p);
        case (k)
            kAdd, kBcond: core = r.dst + r.src;
            kSub:         core = r.dst - r.src;
            kMul:         core = r.dst * r.src;
            kAnd:         core = r.dst & r.src;
            kOr:          core = r.dst | r.src;
            kXor:         core = r.dst ^ r.src;
            kNot:         core = ~r.dst;
            kMov, kJcond: core = r.src;
            kLui:         core = {r.src[7:0], r.dst[7:0]};
            kLsh:  core = r.src[4] ? shiftRight(r.dst, rAmt, 1'b0) : r.dst << r.src[3:0];
            kAshu: core = r.src[4] ? shiftRight(r.dst, rAmt, 1'b1) : r.dst << r.src[3:0];
            kShl:         core = r.dst << r.src[3:0];
            kLshR:        core = shiftRight(r.dst, rAmt, 1'b0);
            kAshR:        core = shiftRight(r.dst, rAmt, 1'b1);
            default:      core = 16'h0000;
        endcase
        raw   = 5'b00000;
        raw.z = (core == 16'h0000);
        raw.n = core[15];
        if (k == kAdd) begin
            raw.c = (int'(r.dst) + int'(r.src)) > 65535;
            raw.f = (sSum > 32767) || (sSum < -32768);
        end else if (k == kSub) begin
            raw.c = r.dst < r.src;                   // borrow
            raw.l = r.dst < r.src;
            raw.f = (sDiff > 32767) || (sDiff < -32768);
            raw.n = $signed(r.dst) < $signed(r.src); // signed less
        end
        e.result = core;
        if (k == kBcond || k == kJcond)
            e.result = ct ? core : r.dst;  // not taken keeps dst
        else if (k == kScond)
            e.result = {15'd0, ct};
        e.psr      = (p & ~mask) | (raw & mask);
        e.condTrue = ct;
        e.tag      = r.tag;
        return e;
    endfunction

    ////////////////////
    // stimulus
    task automatic nextCycle();
        @(posedge clk);
        #1;
        rspReady = ($random(seed) & 3) != 0;  // ~25% stalls
    endtask

    task automatic makeReq(input int n, output execPkg::execReq_t r);
        int pick;
        pick   = $random(seed) & 7;
        r.op   = 4'($random(seed));
        r.func = 4'($random(seed));
        r.cond = 4'($random(seed));
        r.dst  = 16'($random(seed));
        r.src  = 16'($random(seed));
        r.tag  = 8'(n);
        // lean on shift, special and branch classes
        case (pick)
            0: r.op = cr16Pkg::opShift;
            1, 4: r.op = cr16Pkg::opSpecial;
            2: r.op = cr16Pkg::opBcond;
            3: r.op = cr16Pkg::opReg;
            default: ;
        endcase
        if (r.op == cr16Pkg::opShift && ($random(seed) & 3) != 0)
            r.func = r.func & 4'h7;  // mostly defined shift forms
        if (r.op == cr16Pkg::opSpecial && ($random(seed) & 3) != 0)
            r.func = ($random(seed) & 1) ? cr16Pkg::fnScond : cr16Pkg::fnJcond;
        if (($random(seed) & 3) == 0)
            r.src[4:0] = 5'h10;  // -16
        if (($random(seed) & 7) == 1)
            r.src = r.dst;       // equal operands, zero flags
    endtask

    task automatic sendReq(input execPkg::execReq_t r);
        int   waits;
        logic done;
        waits    = 0;
        done     = 1'b0;
        reqValid = 1'b1;
        req      = r;
        while (!done && !timedOut) begin
            @(negedge clk);
            if (reqReady) begin  // transfers on the coming edge
                expQ.push_back(predict(r, modelPsr));
                modelPsr = expQ[$].psr;
                accepted++;
                done = 1'b1;
            end
            nextCycle();
            waits++;
            if (!done && waits > 50) begin
                timedOut = 1'b1;
                otherErrors++;
                $display("request tag %h was never accepted", r.tag);
            end
        end
    endtask

    task automatic checkField(input string name, input logic [15:0] got,
                              input logic [15:0] exp, input logic [7:0] tag);
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch %s tag %h: got %h expected %h", name, tag, got, exp);
        end
    endtask

    ////////////////////
    // scoreboard, rsp is settled by the falling edge
    always @(negedge clk) begin
        execPkg::execRsp_t e;
        if (arstN && rspValid && rspReady) begin
            received++;
            assert (expQ.size() != 0) else begin
                otherErrors++;
                $display("response seen with no request outstanding");
            end
            if (expQ.size() != 0) begin
                e = expQ.pop_front();
                checkField("tag", 16'(rsp.tag), 16'(e.tag), e.tag);
                checkField("result", rsp.result, e.result, e.tag);
                checkField("psr", 16'(rsp.psr), 16'(e.psr), e.tag);
                checkField("condTrue", 16'(rsp.condTrue), 16'(e.condTrue), e.tag);
            end
        end
    end

    initial begin
        execPkg::execReq_t r;
        int                drainWaits;
        arstN    = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        rspReady = 1'b0;
        modelPsr = 5'b00000;
        timedOut = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        arstN = 1'b1;
        assert (!rspValid && reqReady) else begin
            otherErrors++;
            $display("stage is not idle and ready after reset");
        end

        for (int n = 0; n < numReqs && !timedOut; n++) begin
            makeReq(n, r);
            sendReq(r);
            if (($random(seed) & 7) == 0) begin
                reqValid = 1'b0;  // idle gap
                nextCycle();
            end
        end
        reqValid = 1'b0;

        // let the last responses out
        drainWaits = 0;
        while (!timedOut && expQ.size() != 0) begin
            nextCycle();
            drainWaits++;
            if (drainWaits > 100) begin
                timedOut = 1'b1;
                otherErrors++;
                $display("%0d responses never arrived", expQ.size());
            end
        end
        assert (accepted == received) else begin
            otherErrors++;
            $display("accepted %0d requests but saw %0d responses", accepted, received);
        end

        $display("requests %0d responses %0d mismatches %0d other errors %0d assertion errors %0d",
                 accepted, received, mismatches, otherErrors,
                 execUnit_i.execUnitChecker_i.failCount);
        if (mismatches + otherErrors + execUnit_i.execUnitChecker_i.failCount == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire
